// ==== logic/mbox_macros.svh ====
// Mailbox, fuse key and host bus size macros
`ifndef MBOX_MACROS_SVH
`define MBOX_MACROS_SVH

// Mailbox SRAM geometry
`define MBOX_DEPTH 64
`define MBOX_ADDR_W 6
`define MBOX_DATA_W 32

// Fuse key size in dwords
`define FUSE_KEY_DWORDS 4

// Host bus byte address width
`define APB_ADDR_W 8

`endif

// ==== logic/soc_ifc_pkg.sv ====
// Host bus request and response types and the register offset map
`include "mbox_macros.svh"

package soc_ifc_pkg;

    // Host to slave, held stable until ready
    typedef struct packed {
        logic                    sel;
        logic                    enable;
        logic                    write;
        logic [`APB_ADDR_W-1:0]  addr;
        logic [`MBOX_DATA_W-1:0] wdata;
    } apb_req_t;

    // Slave to host
    typedef struct packed {
        logic [`MBOX_DATA_W-1:0] rdata;
        logic                    ready;
        logic                    slverr;
    } apb_rsp_t;

    // Register byte offsets
    typedef enum logic [`APB_ADDR_W-1:0] {
        FUSE_KEY0     = 'h00,
        FUSE_KEY1     = 'h04,
        FUSE_KEY2     = 'h08,
        FUSE_KEY3     = 'h0C,
        FUSE_DONE     = 'h10,
        MBOX_LOCK     = 'h14,
        MBOX_DLEN     = 'h18,
        MBOX_DATAIN   = 'h1C,
        MBOX_DATAOUT  = 'h20,
        MBOX_EXECUTE  = 'h24,
        MBOX_STATUS   = 'h28,
        MBOX_CHECKSUM = 'h2C
    } reg_offset_e;

endpackage

// ==== logic/mbox_pkg.sv ====
// Mailbox SRAM request, engine command and engine status types
`include "mbox_macros.svh"

package mbox_pkg;

    // One SRAM access, read data comes back a cycle later
    typedef struct packed {
        logic                    cs;
        logic                    we;
        logic [`MBOX_ADDR_W-1:0] addr;
        logic [`MBOX_DATA_W-1:0] wdata;
    } sram_req_t;

    // Register block to engine
    typedef struct packed {
        logic                                          start;
        // Drops done and data available
        logic                                          clear;
        logic [`MBOX_ADDR_W:0]                         dlen;
        logic [`FUSE_KEY_DWORDS-1:0][`MBOX_DATA_W-1:0] key;
    } mbox_cmd_t;

    // Engine to register block
    typedef struct packed {
        logic                    busy;
        logic                    done;
        logic [`MBOX_DATA_W-1:0] checksum;
    } mbox_status_t;

endpackage

// ==== logic/soc_ifc_regs.sv ====
// APB register block with fuse key, mailbox lock, data pointers and execute control
`include "mbox_macros.svh"

module soc_ifc_regs
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  soc_ifc_pkg::apb_req_t   apb_req,
    output soc_ifc_pkg::apb_rsp_t   apb_rsp,
    output mbox_pkg::sram_req_t     host_sram,
    input  logic [`MBOX_DATA_W-1:0] host_rdata,
    output mbox_pkg::mbox_cmd_t     cmd,
    input  mbox_pkg::mbox_status_t  status,
    output logic                    ready_for_fuses,
    output logic                    ready_for_mb_processing
);

    localparam int KEY_IDX_W = $clog2(`FUSE_KEY_DWORDS);

    logic [`FUSE_KEY_DWORDS-1:0][`MBOX_DATA_W-1:0] fuse_key;
    logic                                          fuse_done;
    logic                                          mbox_lock;
    logic [`MBOX_ADDR_W:0]                         dlen;
    logic [`MBOX_ADDR_W:0]                         wr_ptr;
    logic [`MBOX_ADDR_W-1:0]                       rd_ptr;
    logic                                          rd_wait;
    logic                                          start_q;
    logic                                          clear_q;

    soc_ifc_pkg::reg_offset_e offset;
    logic                     access;
    logic                     mapped;
    logic                     is_key;
    logic                     mbox_reg;
    logic                     is_datain;
    logic                     is_dataout;
    logic                     is_execute;
    logic                     engine_busy;
    logic                     slv_err;
    logic                     dataout_rd;
    logic                     wr_ok;
    logic                     rd_ok;
    logic [`MBOX_DATA_W-1:0]  rdata;

    assign offset = soc_ifc_pkg::reg_offset_e'(apb_req.addr);
    assign access = apb_req.sel && apb_req.enable;

    // Address decode and read mux
    always_comb
    begin
        mapped   = 1'b1;
        is_key   = 1'b0;
        mbox_reg = 1'b0;
        rdata    = '0;
        case (offset)
            soc_ifc_pkg::FUSE_KEY0, soc_ifc_pkg::FUSE_KEY1,
            soc_ifc_pkg::FUSE_KEY2, soc_ifc_pkg::FUSE_KEY3:
                is_key = 1'b1;
            soc_ifc_pkg::FUSE_DONE:
                rdata[0] = fuse_done;
            soc_ifc_pkg::MBOX_LOCK:
                rdata[0] = mbox_lock;
            soc_ifc_pkg::MBOX_DLEN:
            begin
                mbox_reg             = 1'b1;
                rdata[`MBOX_ADDR_W:0] = dlen;
            end
            soc_ifc_pkg::MBOX_DATAIN:
                mbox_reg = 1'b1;
            soc_ifc_pkg::MBOX_DATAOUT:
            begin
                mbox_reg = 1'b1;
                rdata    = host_rdata;
            end
            soc_ifc_pkg::MBOX_EXECUTE:
                mbox_reg = 1'b1;
            soc_ifc_pkg::MBOX_STATUS:
                rdata[1:0] = {status.done, status.busy};
            soc_ifc_pkg::MBOX_CHECKSUM:
                rdata = status.checksum;
            default:
                mapped = 1'b0;
        endcase
    end

    assign is_datain  = offset == soc_ifc_pkg::MBOX_DATAIN;
    assign is_dataout = offset == soc_ifc_pkg::MBOX_DATAOUT;
    assign is_execute = offset == soc_ifc_pkg::MBOX_EXECUTE;

    // Start pulse in flight counts as busy
    assign engine_busy = status.busy || start_q;

    assign slv_err = !mapped
        || (mbox_reg && (!mbox_lock || engine_busy))
        || (is_datain && wr_ptr == (`MBOX_ADDR_W+1)'(`MBOX_DEPTH))
        || (is_execute && apb_req.write && apb_req.wdata[0] && !fuse_done);

    // Data-out read stalls one cycle for the SRAM
    assign dataout_rd = access && is_dataout && !apb_req.write && !slv_err;

    assign apb_rsp.ready  = !(dataout_rd && !rd_wait);
    assign apb_rsp.slverr = access && slv_err;
    assign apb_rsp.rdata  = rdata;

    assign wr_ok = access && apb_rsp.ready && apb_req.write && !slv_err;
    assign rd_ok = access && apb_rsp.ready && !apb_req.write && !slv_err;

    // Host SRAM port, write at wr_ptr or read at rd_ptr
    always_comb
    begin
        host_sram.we    = wr_ok && is_datain;
        host_sram.cs    = host_sram.we || (dataout_rd && !rd_wait);
        host_sram.addr  = host_sram.we ? wr_ptr[`MBOX_ADDR_W-1:0] : rd_ptr;
        host_sram.wdata = apb_req.wdata;
    end

    // Key locks once fuses are done
    always_ff @(posedge clk)
    begin
        if (wr_ok && is_key && !fuse_done)
        begin
            fuse_key[apb_req.addr[KEY_IDX_W+1:2]] <= apb_req.wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            fuse_done <= 1'b0;
            mbox_lock <= 1'b0;
            dlen      <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            rd_wait   <= 1'b0;
            start_q   <= 1'b0;
            clear_q   <= 1'b0;
        end
        else
        begin
            start_q <= 1'b0;
            clear_q <= 1'b0;
            rd_wait <= dataout_rd && !rd_wait;
            if (wr_ok)
            begin
                case (offset)
                    soc_ifc_pkg::FUSE_DONE:
                        if (apb_req.wdata[0])
                        begin
                            fuse_done <= 1'b1;
                        end
                    soc_ifc_pkg::MBOX_DLEN:
                        dlen <= apb_req.wdata[`MBOX_ADDR_W:0];
                    soc_ifc_pkg::MBOX_DATAIN:
                        wr_ptr <= wr_ptr + 1'b1;
                    soc_ifc_pkg::MBOX_EXECUTE:
                        if (apb_req.wdata[0])
                        begin
                            start_q <= 1'b1;
                        end
                        else
                        begin
                            // Release and rewind for the next message
                            clear_q   <= 1'b1;
                            mbox_lock <= 1'b0;
                            wr_ptr    <= '0;
                            rd_ptr    <= '0;
                        end
                    default:
                    begin
                    end
                endcase
            end
            if (rd_ok && offset == soc_ifc_pkg::MBOX_LOCK)
            begin
                mbox_lock <= 1'b1;
            end
            if (rd_ok && is_dataout)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign cmd.start = start_q;
    assign cmd.clear = clear_q;
    assign cmd.dlen  = dlen;
    assign cmd.key   = fuse_key;

    assign ready_for_fuses         = !fuse_done;
    assign ready_for_mb_processing = fuse_done;

endmodule

// ==== logic/mbox_engine.sv ====
// Mailbox engine with in-place key XOR transform, checksum and SRAM port mux
`include "mbox_macros.svh"

module mbox_engine
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  mbox_pkg::mbox_cmd_t     cmd,
    output mbox_pkg::mbox_status_t  status,
    input  mbox_pkg::sram_req_t     host_sram,
    output logic [`MBOX_DATA_W-1:0] host_rdata,
    output mbox_pkg::sram_req_t     sram,
    input  logic [`MBOX_DATA_W-1:0] sram_rdata,
    output logic                    mailbox_data_avail
);

    localparam int KEY_IDX_W = $clog2(`FUSE_KEY_DWORDS);

    // Three cycles per word
    typedef enum logic [1:0] {
        IDLE,
        READ,
        CAPTURE,
        WRITE
    } state_e;

    state_e                  state;
    logic [`MBOX_ADDR_W:0]   idx;
    logic [`MBOX_DATA_W-1:0] word_q;
    logic [`MBOX_DATA_W-1:0] checksum;
    logic                    done;
    logic                    last_word;
    mbox_pkg::sram_req_t     eng_req;

    // A zero length still runs one word
    assign last_word = (idx + 1'b1) >= cmd.dlen;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= IDLE;
            idx      <= '0;
            checksum <= '0;
            done     <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (cmd.start)
                    begin
                        state    <= READ;
                        idx      <= '0;
                        checksum <= '0;
                        done     <= 1'b0;
                    end
                READ:
                    state <= CAPTURE;
                CAPTURE:
                    state <= WRITE;
                WRITE:
                begin
                    checksum <= checksum + word_q;
                    if (last_word)
                    begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                    else
                    begin
                        idx   <= idx + 1'b1;
                        state <= READ;
                    end
                end
                default:
                    state <= IDLE;
            endcase
            if (cmd.clear)
            begin
                done <= 1'b0;
            end
        end
    end

    // Key dword picked by word index modulo key size
    always_ff @(posedge clk)
    begin
        if (state == CAPTURE)
        begin
            word_q <= sram_rdata ^ cmd.key[idx[KEY_IDX_W-1:0]];
        end
    end

    always_comb
    begin
        eng_req.cs    = (state == READ) || (state == WRITE);
        eng_req.we    = state == WRITE;
        eng_req.addr  = idx[`MBOX_ADDR_W-1:0];
        eng_req.wdata = word_q;
    end

    // Host only reaches the SRAM while the engine is idle
    assign sram       = (state == IDLE) ? host_sram : eng_req;
    assign host_rdata = sram_rdata;

    assign status.busy     = state != IDLE;
    assign status.done     = done;
    assign status.checksum = checksum;

    assign mailbox_data_avail = done;

endmodule

// ==== logic/mbox_top.sv ====
// Mailbox subsystem top with register block and engine between APB and SRAM ports
`include "mbox_macros.svh"

module mbox_top
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  soc_ifc_pkg::apb_req_t   apb_req,
    output soc_ifc_pkg::apb_rsp_t   apb_rsp,
    output mbox_pkg::sram_req_t     sram,
    input  logic [`MBOX_DATA_W-1:0] sram_rdata,
    output logic                    ready_for_fuses,
    output logic                    ready_for_mb_processing,
    output logic                    mailbox_data_avail
);

    // Register block to engine
    mbox_pkg::sram_req_t     host_sram;
    logic [`MBOX_DATA_W-1:0] host_rdata;
    mbox_pkg::mbox_cmd_t     cmd;
    mbox_pkg::mbox_status_t  status;

    soc_ifc_regs i_soc_ifc_regs
    (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .apb_req                 (apb_req),
        .apb_rsp                 (apb_rsp),
        .host_sram               (host_sram),
        .host_rdata              (host_rdata),
        .cmd                     (cmd),
        .status                  (status),
        .ready_for_fuses         (ready_for_fuses),
        .ready_for_mb_processing (ready_for_mb_processing)
    );

    // Owns the exported SRAM port
    mbox_engine i_mbox_engine
    (
        .clk                (clk),
        .rst_n              (rst_n),
        .cmd                (cmd),
        .status             (status),
        .host_sram          (host_sram),
        .host_rdata         (host_rdata),
        .sram               (sram),
        .sram_rdata         (sram_rdata),
        .mailbox_data_avail (mailbox_data_avail)
    );

endmodule

// ==== sim/mbox_tb_services.sv ====
// Mailbox SRAM model with one-cycle read latency on the exported SRAM port
`include "mbox_macros.svh"

module mbox_tb_services
(
    input  logic                    clk,
    input  mbox_pkg::sram_req_t     sram,
    output logic [`MBOX_DATA_W-1:0] sram_rdata
);

    logic [`MBOX_DATA_W-1:0] mem [`MBOX_DEPTH];

    // Fill depends on every address bit so stale words stand out
    initial
    begin
        for (int i = 0; i < `MBOX_DEPTH; i++)
        begin
            mem[i] = 32'hC0DE_0000 ^ (32'(i) * 32'h0101_0101);
        end
        sram_rdata <= '0;
    end

    // Read data registered and valid the cycle after select
    always @(posedge clk)
    begin
        if (sram.cs)
        begin
            if (sram.we)
            begin
                mem[sram.addr] = sram.wdata;
            end
            else
            begin
                sram_rdata <= mem[sram.addr];
            end
        end
    end

endmodule

// ==== sim/mbox_top_tb.sv ====
// Mailbox subsystem testbench with host bus driver, LFSR, reference model and checks
`include "mbox_macros.svh"

module mbox_top_tb;

    localparam int ROUNDS = 8;
    // Eight rounds of up to 64 words at about ten cycles a word, plus setup
    localparam int TIMEOUT_CYCLES = 10000;

    logic                    clk = 1'b0;
    logic                    rst_n;
    soc_ifc_pkg::apb_req_t   apb_req;
    soc_ifc_pkg::apb_rsp_t   apb_rsp;
    mbox_pkg::sram_req_t     sram;
    logic [`MBOX_DATA_W-1:0] sram_rdata;
    logic                    ready_for_fuses;
    logic                    ready_for_mb_processing;
    logic                    mailbox_data_avail;

    logic [31:0]             lfsr_state;
    int                      cycles = 0;
    int                      msg_len;
    logic                    round_ready = 1'b0;
    logic [`MBOX_DATA_W-1:0] key [`FUSE_KEY_DWORDS];
    logic [`MBOX_DATA_W-1:0] msg [`MBOX_DEPTH];
    logic [`MBOX_DATA_W-1:0] exp_words [`MBOX_DEPTH];
    logic [`MBOX_DATA_W-1:0] got_words [`MBOX_DEPTH];
    logic [`MBOX_DATA_W-1:0] got_checksum;

    mbox_top i_mbox_top
    (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .apb_req                 (apb_req),
        .apb_rsp                 (apb_rsp),
        .sram                    (sram),
        .sram_rdata              (sram_rdata),
        .ready_for_fuses         (ready_for_fuses),
        .ready_for_mb_processing (ready_for_mb_processing),
        .mailbox_data_avail      (mailbox_data_avail)
    );

    mbox_tb_services i_mbox_tb_services
    (
        .clk        (clk),
        .sram       (sram),
        .sram_rdata (sram_rdata)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout, the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Word XOR key dword at index modulo four, wrapping sum of the results
    function automatic logic [31:0] reference_model(input int len);
        logic [31:0] sum;
        sum = '0;
        for (int i = 0; i < len; i++)
        begin
            exp_words[i] = msg[i] ^ key[i % `FUSE_KEY_DWORDS];
            sum = sum + exp_words[i];
        end
        return sum;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp)
        begin
            $display("Fail at time %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "Mismatch in %s", what);
        end
    endtask

    // Setup phase, then access phases until ready
    task automatic host_transfer(input logic write, input logic [`APB_ADDR_W-1:0] addr,
                                 input logic [31:0] wdata, output logic [31:0] rdata,
                                 output logic slverr);
        @(posedge clk);
        apb_req.sel    <= 1'b1;
        apb_req.enable <= 1'b0;
        apb_req.write  <= write;
        apb_req.addr   <= addr;
        apb_req.wdata  <= wdata;
        @(posedge clk);
        apb_req.enable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.ready)
        begin
            @(negedge clk);
        end
        rdata  = apb_rsp.rdata;
        slverr = apb_rsp.slverr;
        @(posedge clk);
        apb_req.sel    <= 1'b0;
        apb_req.enable <= 1'b0;
    endtask

    task automatic write_reg(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        slverr;
        host_transfer(1'b1, addr, data, rdata, slverr);
        check_equal(32'(slverr), 32'(exp_err), $sformatf("slave error on write to %h", addr));
    endtask

    task automatic read_reg(input logic [`APB_ADDR_W-1:0] addr, input logic exp_err,
                            output logic [31:0] data);
        logic slverr;
        host_transfer(1'b0, addr, '0, data, slverr);
        check_equal(32'(slverr), 32'(exp_err), $sformatf("slave error on read of %h", addr));
    endtask

    // Compares each finished round against the reference model
    initial
    begin
        logic [31:0] exp_checksum;
        forever
        begin
            wait (round_ready);
            exp_checksum = reference_model(msg_len);
            for (int i = 0; i < msg_len; i++)
            begin
                check_equal(got_words[i], exp_words[i], $sformatf("data-out word %0d", i));
            end
            check_equal(got_checksum, exp_checksum, "mailbox checksum");
            round_ready = 1'b0;
        end
    end

    initial
    begin
        logic [31:0] data;
        lfsr_state = 32'h2ae0cbed;
        rst_n   <= 1'b0;
        apb_req <= '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        check_equal(32'(ready_for_fuses), 32'd1, "ready_for_fuses after reset");
        check_equal(32'(ready_for_mb_processing), 32'd0, "ready_for_mb_processing after reset");
        check_equal(32'(mailbox_data_avail), 32'd0, "mailbox_data_avail after reset");
        check_equal(32'(sram.cs), 32'd0, "SRAM select after reset");
        check_equal(32'(apb_rsp.ready), 32'd1, "bus ready after reset");
        read_reg(soc_ifc_pkg::MBOX_STATUS, 1'b0, data);
        check_equal(data, 32'd0, "status after reset");
        read_reg(soc_ifc_pkg::MBOX_CHECKSUM, 1'b0, data);
        check_equal(data, 32'd0, "checksum after reset");

        for (int k = 0; k < `FUSE_KEY_DWORDS; k++)
        begin
            key[k] = random_bits(32);
            write_reg((`APB_ADDR_W)'(4 * k), key[k], 1'b0);
        end
        write_reg(soc_ifc_pkg::FUSE_DONE, 32'd1, 1'b0);
        @(negedge clk);
        check_equal(32'(ready_for_fuses), 32'd0, "ready_for_fuses after fuse done");
        check_equal(32'(ready_for_mb_processing), 32'd1, "ready_for_mb_processing after fuse done");
        // Key is frozen, the reference keeps the loaded value
        write_reg(soc_ifc_pkg::FUSE_KEY0, ~key[0], 1'b0);

        write_reg(soc_ifc_pkg::MBOX_DATAIN, 32'h1234_5678, 1'b1);
        read_reg(8'h30, 1'b1, data);
        write_reg(8'hFC, 32'h0, 1'b1);

        for (int r = 0; r < ROUNDS; r++)
        begin
            // First round fills the whole mailbox
            msg_len = (r == 0) ? `MBOX_DEPTH : int'(random_bits(6)) + 1;
            read_reg(soc_ifc_pkg::MBOX_LOCK, 1'b0, data);
            check_equal(data, 32'd0, "lock free at round start");
            read_reg(soc_ifc_pkg::MBOX_LOCK, 1'b0, data);
            check_equal(data, 32'd1, "lock taken");
            write_reg(soc_ifc_pkg::MBOX_DLEN, 32'(msg_len), 1'b0);
            for (int i = 0; i < msg_len; i++)
            begin
                msg[i] = random_bits(32);
                write_reg(soc_ifc_pkg::MBOX_DATAIN, msg[i], 1'b0);
            end
            if (msg_len == `MBOX_DEPTH)
            begin
                write_reg(soc_ifc_pkg::MBOX_DATAIN, 32'hFFFF_FFFF, 1'b1);
            end
            write_reg(soc_ifc_pkg::MBOX_EXECUTE, 32'd1, 1'b0);
            read_reg(soc_ifc_pkg::MBOX_STATUS, 1'b0, data);
            check_equal(data, 32'd1, "status busy while running");

            while (!mailbox_data_avail)
            begin
                @(negedge clk);
            end
            read_reg(soc_ifc_pkg::MBOX_STATUS, 1'b0, data);
            check_equal(data, 32'd2, "status done after run");
            read_reg(soc_ifc_pkg::MBOX_CHECKSUM, 1'b0, got_checksum);
            for (int i = 0; i < msg_len; i++)
            begin
                read_reg(soc_ifc_pkg::MBOX_DATAOUT, 1'b0, got_words[i]);
            end
            round_ready = 1'b1;
            wait (!round_ready);

            // Release the mailbox for the next round
            write_reg(soc_ifc_pkg::MBOX_EXECUTE, 32'd0, 1'b0);
            read_reg(soc_ifc_pkg::MBOX_STATUS, 1'b0, data);
            check_equal(data, 32'd0, "status after release");
            @(negedge clk);
            check_equal(32'(mailbox_data_avail), 32'd0, "mailbox_data_avail after release");
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+logic
logic/soc_ifc_pkg.sv
logic/mbox_pkg.sv
logic/soc_ifc_regs.sv
logic/mbox_engine.sv
logic/mbox_top.sv
sim/mbox_tb_services.sv
sim/mbox_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the mailbox testbench with Verilator and run it, the exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f files.f --top-module mbox_top_tb -o mbox_top_tb &&
./obj_dir/mbox_top_tb ||
exit 1
